/* i2c_link.f */
i2c_link_pkg.sv
i2c_host_port.sv
i2c_master.sv
i2c_slave.sv
i2c_result_regs.sv
i2c_link_top.sv
i2c_link_properties.sv
tb_i2c_link.sv

/* tb_i2c_link.sv */
/*
 * Testbench for the serial link top level
 * Wishbone register traffic checked against a model of the target byte
 */

`timescale 1ns/1ps

module tb_i2c_link;

  localparam int DRIVE_DLY   = 1;
  localparam int ACK_TIMEOUT = 10;
  localparam int POLL_LIMIT  = 40;
  localparam int RAND_XFERS  = 40;

  logic                  SCL;
  logic                  rst_n;
  i2c_link_pkg::wb_req_t wb_req;
  i2c_link_pkg::wb_rsp_t wb_rsp;

  int                    seed = 32'hdb14ccc3;
  // Model of the target's storage byte and the last captured read byte
  logic [7:0]            model_mem;
  logic [7:0]            model_rdata;

  i2c_link_top UUT (
    .SCL    (SCL),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    SCL = 1'b0;
    forever #2 SCL = ~SCL;
  end

  // ------------------------------------------------------------------------
  // Reference model and compare tasks
  // ------------------------------------------------------------------------

  function automatic i2c_link_pkg::xfer_result_t ref_link(input i2c_link_pkg::xfer_op_e op,
                                                          input logic [6:0] target,
                                                          input logic [7:0] wdata);
    i2c_link_pkg::xfer_result_t res;
    res.nack = (target != i2c_link_pkg::SLAVE_ADDR);
    // Only an acknowledged transfer touches the target or the capture
    if (!res.nack) begin
      if (op == i2c_link_pkg::op_write) begin
        model_mem = wdata;
      end else begin
        model_rdata = model_mem;
      end
    end
    res.rdata = model_rdata;
    return res;
  endfunction

  function automatic i2c_link_pkg::link_status_t status_of(input logic busy, input logic done,
                                                           input logic nack,
                                                           input logic overrun);
    i2c_link_pkg::link_status_t st;
    st.busy    = busy;
    st.done    = done;
    st.nack    = nack;
    st.overrun = overrun;
    return st;
  endfunction

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_status(input string what, input i2c_link_pkg::link_status_t got,
                              input i2c_link_pkg::link_status_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b (busy,done,nack,overrun)",
               $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------------------
  // Wishbone access
  // ------------------------------------------------------------------------

  task automatic access_reg(input logic we, input logic [1:0] adr, input logic [7:0] dat,
                            output logic [7:0] rd);
    int waited;
    @(posedge SCL);
    #DRIVE_DLY;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    waited = 0;
    do begin
      @(posedge SCL);
      #DRIVE_DLY;
      waited++;
    end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
    if (!wb_rsp.ack) begin
      $display("Timeout: no Wishbone ack for access to register %0d", adr);
      abort_run();
    end
    rd     = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic write_reg(input logic [1:0] adr, input logic [7:0] dat);
    logic [7:0] unused;
    access_reg(1'b1, adr, dat, unused);
  endtask

  task automatic read_reg(input logic [1:0] adr, output logic [7:0] rd);
    access_reg(1'b0, adr, 8'h00, rd);
  endtask

  task automatic read_status(output i2c_link_pkg::link_status_t st);
    logic [7:0] raw;
    read_reg(i2c_link_pkg::REG_STATUS, raw);
    st = i2c_link_pkg::link_status_t'(raw[3:0]);
  endtask

  // Poll status until the transfer reports done
  task automatic wait_done(output i2c_link_pkg::link_status_t st);
    int polls;
    polls = 0;
    st    = '0;
    while (!st.done && polls < POLL_LIMIT) begin
      read_status(st);
      polls++;
    end
    if (!st.done) begin
      $display("Timeout: transfer never reported done after %0d status polls", polls);
      abort_run();
    end
  endtask

  task automatic idle_gap(input int max_cycles);
    logic [31:0] r;
    r = $random(seed);
    if (max_cycles > 0) begin
      repeat (r % (max_cycles + 1)) @(posedge SCL);
    end
  endtask

  function automatic logic [6:0] other_addr();
    logic [31:0] r;
    r = $random(seed);
    return (r[6:0] == i2c_link_pkg::SLAVE_ADDR) ? (r[6:0] ^ 7'h01) : r[6:0];
  endfunction

  // One full transaction through the register map, checked end to end
  task automatic run_xfer(input i2c_link_pkg::xfer_op_e op, input logic [6:0] target,
                          input logic [7:0] wdata, input int gap_max);
    i2c_link_pkg::xfer_result_t exp;
    i2c_link_pkg::link_status_t st;
    logic [7:0]                 rd;
    write_reg(i2c_link_pkg::REG_TARGET, {1'b0, target});
    idle_gap(gap_max);
    write_reg(i2c_link_pkg::REG_DATA, wdata);
    idle_gap(gap_max);
    write_reg(i2c_link_pkg::REG_CMD, {7'd0, op});
    exp = ref_link(op, target, wdata);
    wait_done(st);
    check_status("status at end of transfer", st, status_of(1'b0, 1'b1, exp.nack, 1'b0));
    idle_gap(gap_max);
    read_reg(i2c_link_pkg::REG_DATA, rd);
    check_byte("rdata", rd, exp.rdata);
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------

  initial begin
    i2c_link_pkg::link_status_t st;
    i2c_link_pkg::xfer_result_t exp;
    logic [7:0]                 rd;
    logic [31:0]                r;
    logic [6:0]                 target;
    int                         i;

    rst_n       = 1'b0;
    wb_req      = '0;
    model_mem   = '0;
    model_rdata = '0;
    repeat (16) @(posedge SCL);
    #DRIVE_DLY;
    rst_n = 1'b1;

    // Reset state
    read_status(st);
    check_status("status after reset", st, status_of(1'b0, 1'b0, 1'b0, 1'b0));
    run_xfer(i2c_link_pkg::op_read, i2c_link_pkg::SLAVE_ADDR, 8'h00, 0);

    // Write then read back
    r = $random(seed);
    run_xfer(i2c_link_pkg::op_write, i2c_link_pkg::SLAVE_ADDR, r[7:0], 0);
    run_xfer(i2c_link_pkg::op_read, i2c_link_pkg::SLAVE_ADDR, ~r[7:0], 0);

    // Wrong address leaves the stored byte alone
    run_xfer(i2c_link_pkg::op_write, other_addr(), ~r[7:0], 0);
    run_xfer(i2c_link_pkg::op_read, other_addr(), 8'h00, 0);
    run_xfer(i2c_link_pkg::op_read, i2c_link_pkg::SLAVE_ADDR, 8'h00, 0);

    // Second command while busy is dropped
    r = $random(seed);
    write_reg(i2c_link_pkg::REG_TARGET, {1'b0, i2c_link_pkg::SLAVE_ADDR});
    write_reg(i2c_link_pkg::REG_DATA, r[7:0]);
    write_reg(i2c_link_pkg::REG_CMD, {7'd0, i2c_link_pkg::op_write});
    exp = ref_link(i2c_link_pkg::op_write, i2c_link_pkg::SLAVE_ADDR, r[7:0]);
    write_reg(i2c_link_pkg::REG_CMD, {7'd0, i2c_link_pkg::op_read});
    read_status(st);
    check_status("status after dropped command", st, status_of(1'b1, 1'b0, 1'b0, 1'b1));
    wait_done(st);
    check_status("status at end of transfer", st, status_of(1'b0, 1'b1, 1'b0, 1'b0));
    read_status(st);
    check_status("status after clear", st, status_of(1'b0, 1'b0, 1'b0, 1'b0));
    read_reg(i2c_link_pkg::REG_DATA, rd);
    check_byte("rdata", rd, exp.rdata);
    run_xfer(i2c_link_pkg::op_read, i2c_link_pkg::SLAVE_ADDR, 8'h00, 0);

    // Random mixed traffic, about one in four to a foreign address
    for (i = 0; i < RAND_XFERS; i++) begin
      r      = $random(seed);
      target = (r[2:1] == 2'd0) ? other_addr() : i2c_link_pkg::SLAVE_ADDR;
      run_xfer(i2c_link_pkg::xfer_op_e'(r[0]), target, r[15:8], 3);
    end

    repeat (4) @(posedge SCL);
    if (UUT.u_master.u_props.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("Protocol assertions failed %0d times", UUT.u_master.u_props.fail_count);
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* i2c_link_properties.sv */
/*
 * Bus master protocol checks
 * State order, line release in acknowledge slots, NACK handling, busy
 */

`timescale 1ns/1ps

module i2c_link_properties (
  input logic                        SCL,
  input logic                        rst_n,
  input i2c_link_pkg::master_state_e state,
  input logic                        sda,
  input logic                        m_sda,
  input logic                        busy
);

  // Read back by the testbench at the end of the run
  int fail_count = 0;

  // ------------------------------------------------------------------------
  // Transaction opening: idle, start, address
  // ------------------------------------------------------------------------

  a_idle_exit: assert property (@(posedge SCL) disable iff (!rst_n)
    (state == i2c_link_pkg::ms_idle) |=>
      (state inside {i2c_link_pkg::ms_idle, i2c_link_pkg::ms_start}))
    else begin
      fail_count = fail_count + 1;
      $error("master left idle without passing through start");
    end

  a_start_from_idle: assert property (@(posedge SCL) disable iff (!rst_n)
    (state == i2c_link_pkg::ms_start) |-> ($past(state) == i2c_link_pkg::ms_idle))
    else begin
      fail_count = fail_count + 1;
      $error("start state entered from a state other than idle");
    end

  a_start_to_addr: assert property (@(posedge SCL) disable iff (!rst_n)
    (state == i2c_link_pkg::ms_start) |=> (state == i2c_link_pkg::ms_addr))
    else begin
      fail_count = fail_count + 1;
      $error("start state not followed by the address byte");
    end

  // ------------------------------------------------------------------------
  // Acknowledge slots and NACK
  // ------------------------------------------------------------------------

  // Master must let go of the line while the target answers
  a_ack_release: assert property (@(posedge SCL) disable iff (!rst_n)
    (state inside {i2c_link_pkg::ms_addr_ack, i2c_link_pkg::ms_data_ack}) |-> m_sda)
    else begin
      fail_count = fail_count + 1;
      $error("master drives SDA low in an acknowledge slot");
    end

  a_addr_nack_stop: assert property (@(posedge SCL) disable iff (!rst_n)
    (state == i2c_link_pkg::ms_addr_ack && sda) |=> (state == i2c_link_pkg::ms_stop))
    else begin
      fail_count = fail_count + 1;
      $error("address NACK not followed by stop");
    end

  a_data_ack_stop: assert property (@(posedge SCL) disable iff (!rst_n)
    (state == i2c_link_pkg::ms_data_ack) |=> (state == i2c_link_pkg::ms_stop))
    else begin
      fail_count = fail_count + 1;
      $error("data acknowledge slot not followed by stop");
    end

  a_idle_not_busy: assert property (@(posedge SCL) disable iff (!rst_n)
    (state == i2c_link_pkg::ms_idle) |-> !busy)
    else begin
      fail_count = fail_count + 1;
      $error("busy high while the master is idle");
    end

endmodule

bind i2c_master i2c_link_properties u_props (
  .SCL   (SCL),
  .rst_n (rst_n),
  .state (state),
  .sda   (sda),
  .m_sda (m_sda),
  .busy  (busy)
);

/* i2c_link_top.sv */
/*
 * Serial link top level
 * Host port, bus master, on-chip target and result block on one SDA line
 */

`timescale 1ns/1ps

module i2c_link_top (
  input  logic                  SCL,
  input  logic                  rst_n,
  input  i2c_link_pkg::wb_req_t wb_req,
  output i2c_link_pkg::wb_rsp_t wb_rsp
);

  i2c_link_pkg::xfer_cmd_t    cmd;
  logic                       cmd_go;
  logic                       busy;
  i2c_link_pkg::xfer_result_t result;
  logic                       xfer_done;
  logic                       status_clear;
  i2c_link_pkg::link_status_t status;
  logic [7:0]                 rdata;
  logic                       m_sda;
  logic                       s_sda;
  logic                       sda;

  // Wired-AND, either side pulls low
  assign sda = m_sda & s_sda;

  i2c_host_port u_host_port (
    .SCL          (SCL),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .busy         (busy),
    .status       (status),
    .rdata        (rdata),
    .cmd          (cmd),
    .cmd_go       (cmd_go),
    .status_clear (status_clear)
  );

  i2c_master u_master (
    .SCL       (SCL),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_go    (cmd_go),
    .sda       (sda),
    .m_sda     (m_sda),
    .busy      (busy),
    .result    (result),
    .xfer_done (xfer_done)
  );

  i2c_slave u_slave (
    .SCL   (SCL),
    .rst_n (rst_n),
    .sda   (sda),
    .s_sda (s_sda)
  );

  i2c_result_regs u_result_regs (
    .SCL          (SCL),
    .rst_n        (rst_n),
    .result       (result),
    .xfer_done    (xfer_done),
    .busy         (busy),
    .status_clear (status_clear),
    .status       (status),
    .rdata        (rdata)
  );

endmodule

/* i2c_result_regs.sv */
/*
 * Transaction result capture
 * Holds the last read byte plus sticky done and NACK flags for the host
 */

`timescale 1ns/1ps

module i2c_result_regs (
  input  logic                       SCL,
  input  logic                       rst_n,
  input  i2c_link_pkg::xfer_result_t result,
  input  logic                       xfer_done,
  input  logic                       busy,
  input  logic                       status_clear,
  output i2c_link_pkg::link_status_t status,
  output logic [7:0]                 rdata
);

  logic       done_q;
  logic       nack_q;
  logic [7:0] rdata_q;

  always_ff @(posedge SCL) begin
    if (!rst_n) begin
      done_q  <= 1'b0;
      nack_q  <= 1'b0;
      rdata_q <= '0;
    end else begin
      if (xfer_done) begin
        // A finishing transfer wins over a clear on the same edge
        done_q <= 1'b1;
        nack_q <= result.nack;
        // Master's rdata only moves on reads
        if (!result.nack) begin
          rdata_q <= result.rdata;
        end
      end else if (status_clear) begin
        done_q <= 1'b0;
      end
    end
  end

  // Overrun lives in the host port
  assign status = '{busy: busy, done: done_q, nack: nack_q, overrun: 1'b0};
  assign rdata  = rdata_q;

endmodule

/* i2c_slave.sv */
/*
 * On-chip target device with one storage byte
 * Matches its own address, stores written bytes, returns the byte on reads
 */

`timescale 1ns/1ps

module i2c_slave (
  input  logic SCL,
  input  logic rst_n,
  input  logic sda,
  output logic s_sda
);

  i2c_link_pkg::slave_state_e state;
  logic [2:0]                 bit_cnt;
  logic                       last_bit;
  logic [7:0]                 shreg;
  logic [7:0]                 rx_byte;
  logic                       addr_hit;
  logic                       rw_q;
  logic [7:0]                 mem_q;

  assign last_bit = (bit_cnt == 3'd0);

  // Byte complete with the bit on the line now
  assign rx_byte  = {shreg[6:0], sda};
  assign addr_hit = (rx_byte[7:1] == i2c_link_pkg::SLAVE_ADDR);

  always_comb begin
    case (state)
      i2c_link_pkg::ss_addr_ack, i2c_link_pkg::ss_wdata_ack: s_sda = 1'b0;
      i2c_link_pkg::ss_rdata:                                s_sda = shreg[7];
      default:                                               s_sda = 1'b1;
    endcase
  end

  // ------------------------------------------------------------------------
  // Target FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge SCL) begin
    if (!rst_n) begin
      state   <= i2c_link_pkg::ss_idle;
      bit_cnt <= '0;
      mem_q   <= '0;
    end else begin
      case (state)
        i2c_link_pkg::ss_idle: begin
          // Start seen as the line going low
          if (!sda) begin
            bit_cnt <= 3'(i2c_link_pkg::BYTE_BITS - 1);
            state   <= i2c_link_pkg::ss_addr;
          end
        end
        i2c_link_pkg::ss_addr: begin
          bit_cnt <= bit_cnt - 3'd1;
          if (last_bit) begin
            state <= addr_hit ? i2c_link_pkg::ss_addr_ack : i2c_link_pkg::ss_idle;
          end
        end
        i2c_link_pkg::ss_addr_ack: begin
          bit_cnt <= 3'(i2c_link_pkg::BYTE_BITS - 1);
          state   <= rw_q ? i2c_link_pkg::ss_rdata : i2c_link_pkg::ss_wdata;
        end
        i2c_link_pkg::ss_wdata: begin
          bit_cnt <= bit_cnt - 3'd1;
          if (last_bit) begin
            mem_q <= rx_byte;
            state <= i2c_link_pkg::ss_wdata_ack;
          end
        end
        i2c_link_pkg::ss_wdata_ack: state <= i2c_link_pkg::ss_idle;
        i2c_link_pkg::ss_rdata: begin
          bit_cnt <= bit_cnt - 3'd1;
          if (last_bit) begin
            state <= i2c_link_pkg::ss_rdata_ack;
          end
        end
        // Master's NACK slot, nothing follows
        i2c_link_pkg::ss_rdata_ack: state <= i2c_link_pkg::ss_idle;
        default:                    state <= i2c_link_pkg::ss_idle;
      endcase
    end
  end

  // Shift register, in for address and write data, out for read data
  always_ff @(posedge SCL) begin
    case (state)
      i2c_link_pkg::ss_addr, i2c_link_pkg::ss_wdata: shreg <= rx_byte;
      i2c_link_pkg::ss_addr_ack:                     shreg <= mem_q;
      i2c_link_pkg::ss_rdata:                        shreg <= {shreg[6:0], 1'b0};
      default: ;
    endcase
    if (state == i2c_link_pkg::ss_addr && last_bit) begin
      rw_q <= sda;
    end
  end

endmodule

/* i2c_master.sv */
/*
 * Bus master for the two-wire link
 * Sends address and data MSB first, samples acknowledges, reads one byte
 */

`timescale 1ns/1ps

module i2c_master (
  input  logic                       SCL,
  input  logic                       rst_n,
  input  i2c_link_pkg::xfer_cmd_t    cmd,
  input  logic                       cmd_go,
  input  logic                       sda,
  output logic                       m_sda,
  output logic                       busy,
  output i2c_link_pkg::xfer_result_t result,
  output logic                       xfer_done
);

  i2c_link_pkg::master_state_e state;
  logic [2:0]                  bit_cnt;
  logic                        last_bit;
  logic [7:0]                  shreg;
  i2c_link_pkg::xfer_op_e      op_q;
  logic [7:0]                  wdata_q;
  logic [7:0]                  rdata_q;
  logic                        nack_q;

  assign last_bit = (bit_cnt == 3'd0);

  // Line drive, released (high) outside start and shift states
  always_comb begin
    case (state)
      i2c_link_pkg::ms_start:                          m_sda = 1'b0;
      i2c_link_pkg::ms_addr, i2c_link_pkg::ms_wdata:   m_sda = shreg[7];
      default:                                         m_sda = 1'b1;
    endcase
  end

  // ------------------------------------------------------------------------
  // Transaction FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge SCL) begin
    if (!rst_n) begin
      state   <= i2c_link_pkg::ms_idle;
      bit_cnt <= '0;
      nack_q  <= 1'b0;
      rdata_q <= '0;
    end else begin
      case (state)
        i2c_link_pkg::ms_idle: begin
          if (cmd_go) begin
            nack_q <= 1'b0;
            state  <= i2c_link_pkg::ms_start;
          end
        end
        i2c_link_pkg::ms_start: begin
          bit_cnt <= 3'(i2c_link_pkg::BYTE_BITS - 1);
          state   <= i2c_link_pkg::ms_addr;
        end
        i2c_link_pkg::ms_addr: begin
          bit_cnt <= bit_cnt - 3'd1;
          if (last_bit) begin
            state <= i2c_link_pkg::ms_addr_ack;
          end
        end
        i2c_link_pkg::ms_addr_ack: begin
          bit_cnt <= 3'(i2c_link_pkg::BYTE_BITS - 1);
          if (sda) begin
            // Nobody answered
            nack_q <= 1'b1;
            state  <= i2c_link_pkg::ms_stop;
          end else if (op_q == i2c_link_pkg::op_read) begin
            state <= i2c_link_pkg::ms_rdata;
          end else begin
            state <= i2c_link_pkg::ms_wdata;
          end
        end
        i2c_link_pkg::ms_wdata: begin
          bit_cnt <= bit_cnt - 3'd1;
          if (last_bit) begin
            state <= i2c_link_pkg::ms_data_ack;
          end
        end
        i2c_link_pkg::ms_data_ack: begin
          nack_q <= sda;
          state  <= i2c_link_pkg::ms_stop;
        end
        i2c_link_pkg::ms_rdata: begin
          rdata_q <= {rdata_q[6:0], sda};
          bit_cnt <= bit_cnt - 3'd1;
          if (last_bit) begin
            state <= i2c_link_pkg::ms_master_ack;
          end
        end
        // Line stays high, NACK ends the read
        i2c_link_pkg::ms_master_ack: state <= i2c_link_pkg::ms_stop;
        i2c_link_pkg::ms_stop:       state <= i2c_link_pkg::ms_idle;
        default:                     state <= i2c_link_pkg::ms_idle;
      endcase
    end
  end

  // Command copy and transmit shifter
  always_ff @(posedge SCL) begin
    if (state == i2c_link_pkg::ms_idle && cmd_go) begin
      shreg   <= {cmd.target, cmd.op == i2c_link_pkg::op_read};
      op_q    <= cmd.op;
      wdata_q <= cmd.wdata;
    end else if (state == i2c_link_pkg::ms_addr_ack) begin
      shreg <= wdata_q;
    end else if (state == i2c_link_pkg::ms_addr || state == i2c_link_pkg::ms_wdata) begin
      shreg <= {shreg[6:0], 1'b0};
    end
  end

  assign busy      = (state != i2c_link_pkg::ms_idle);
  assign xfer_done = (state == i2c_link_pkg::ms_stop);
  assign result    = '{rdata: rdata_q, nack: nack_q};

endmodule

/* i2c_host_port.sv */
/*
 * Wishbone classic slave for the serial link
 * Holds target and data bytes, launches commands, returns status and read data
 */

`timescale 1ns/1ps

module i2c_host_port (
  input  logic                       SCL,
  input  logic                       rst_n,
  input  i2c_link_pkg::wb_req_t      wb_req,
  output i2c_link_pkg::wb_rsp_t      wb_rsp,
  input  logic                       busy,
  input  i2c_link_pkg::link_status_t status,
  input  logic [7:0]                 rdata,
  output i2c_link_pkg::xfer_cmd_t    cmd,
  output logic                       cmd_go,
  output logic                       status_clear
);

  logic                         req_new;
  logic                         ack_q;
  logic [7:0]                   dat_q;
  logic [6:0]                   target_q;
  logic [7:0]                   wdata_q;
  i2c_link_pkg::xfer_op_e       op_q;
  logic                         go_q;
  logic                         overrun_q;
  i2c_link_pkg::link_status_t   status_view;
  logic [7:0]                   rd_mux;

  // First cycle of an access, ack blocks a second hit
  assign req_new = wb_req.cyc & wb_req.stb & ~ack_q;

  // Clear lands on the same edge that samples the status
  assign status_clear = req_new & ~wb_req.we & (wb_req.adr == i2c_link_pkg::REG_STATUS);

  always_comb begin
    status_view         = status;
    status_view.overrun = overrun_q;
  end

  always_comb begin
    case (wb_req.adr)
      i2c_link_pkg::REG_TARGET: rd_mux = {1'b0, target_q};
      i2c_link_pkg::REG_DATA:   rd_mux = rdata;
      i2c_link_pkg::REG_CMD:    rd_mux = {7'd0, op_q};
      default:                  rd_mux = {4'd0, status_view};
    endcase
  end

  always_ff @(posedge SCL) begin
    if (!rst_n) begin
      ack_q     <= 1'b0;
      go_q      <= 1'b0;
      overrun_q <= 1'b0;
      target_q  <= '0;
      wdata_q   <= '0;
      op_q      <= i2c_link_pkg::op_write;
    end else begin
      ack_q <= req_new;
      go_q  <= 1'b0;
      if (status_clear) begin
        overrun_q <= 1'b0;
      end
      if (req_new && wb_req.we) begin
        case (wb_req.adr)
          i2c_link_pkg::REG_TARGET: target_q <= wb_req.dat[6:0];
          i2c_link_pkg::REG_DATA:   wdata_q  <= wb_req.dat;
          i2c_link_pkg::REG_CMD: begin
            // Only one transaction in flight
            if (busy) begin
              overrun_q <= 1'b1;
            end else begin
              op_q <= i2c_link_pkg::xfer_op_e'(wb_req.dat[0]);
              go_q <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Read data, valid while ack is high
  always_ff @(posedge SCL) begin
    if (req_new) begin
      dat_q <= rd_mux;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: dat_q};
  assign cmd    = '{op: op_q, target: target_q, wdata: wdata_q};
  assign cmd_go = go_q;

endmodule

/* i2c_link_pkg.sv */
/*
 * I2C-style link shared definitions
 * State and opcode enums, bus and transfer structs, register map
 */

package i2c_link_pkg;

  // ------------------------------------------------------------------------
  // Constants
  // ------------------------------------------------------------------------

  // Address the on-chip target answers to
  localparam logic [6:0] SLAVE_ADDR = 7'h50;

  // Wishbone register offsets
  localparam logic [1:0] REG_TARGET = 2'd0;
  localparam logic [1:0] REG_DATA   = 2'd1;
  localparam logic [1:0] REG_CMD    = 2'd2;
  localparam logic [1:0] REG_STATUS = 2'd3;

  localparam int BYTE_BITS = 8;

  // ------------------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------------------

  typedef enum logic [3:0] {
    ms_idle,
    ms_start,
    ms_addr,
    ms_addr_ack,
    ms_wdata,
    ms_data_ack,
    ms_rdata,
    ms_master_ack,
    ms_stop
  } master_state_e;

  typedef enum logic [2:0] {
    ss_idle,
    ss_addr,
    ss_addr_ack,
    ss_wdata,
    ss_wdata_ack,
    ss_rdata,
    ss_rdata_ack
  } slave_state_e;

  // Also the R/W bit sent after the address
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } xfer_op_e;

  // ------------------------------------------------------------------------
  // Structs
  // ------------------------------------------------------------------------

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    xfer_op_e   op;
    logic [6:0] target;
    logic [7:0] wdata;
  } xfer_cmd_t;

  typedef struct packed {
    logic [7:0] rdata;
    logic       nack;
  } xfer_result_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic nack;
    logic overrun;
  } link_status_t;

endpackage
